//--- bench/icache_tb.sv
`timescale 1ns/1ps

module icache_tb;
  localparam int num_ways = 4;
  localparam int num_sets = 8;
  localparam int num_tags = mem_bus_pkg::num_tags;
  localparam logic [63:0] data_key = 64'h9e37_79b9_7f4a_7c15;
  // one fetch waiting behind a full queue and refusals
  localparam int wait_limit = 300;
  // sequential, jumps, same-set revisits, prefetch
  localparam int fetch_count = 64 + 40 + 24 + 6;
  localparam int idle_count = 4;
  localparam int cycle_limit = 2 * (10 + (fetch_count + idle_count) * wait_limit);

  logic                      clock = 1'b0;
  logic                      reset;
  logic [31:0]               fetch_addr;
  logic [63:0]               data_out;
  logic                      valid_out;
  mem_bus_pkg::bus_command_t command;
  logic [31:0]               mem_addr;
  mem_bus_pkg::mem_tag_t     mem_response;
  logic [63:0]               mem_data;
  mem_bus_pkg::mem_tag_t     mem_data_tag;

  int reset_errors = 0;
  int data_errors = 0;
  int request_errors = 0;
  int miss_errors = 0;
  int prefetch_errors = 0;
  int total_errors;
  int cycles = 0;

  // outstanding tags and cache contents as seen from the bus
  logic [num_tags:1]   pending_busy;
  logic [28:0]         pending_line [1:num_tags];
  logic [28:0]         model_line   [num_sets][num_ways];
  logic [num_ways-1:0] model_valid  [num_sets];
  int                  model_victim [num_sets];
  logic [28:0]         evicted_lines [$];
  logic                refused_q;
  logic [31:0]         refused_addr_q;

  always #4 clock = ~clock;

  icache #(
    .NUM_WAYS(num_ways),
    .NUM_SETS(num_sets),
    .QUEUE_DEPTH(8),
    .PREFETCH_COUNT(2)
  ) icache_i (
    .clock(clock),
    .reset(reset),
    .fetch_addr(fetch_addr),
    .data_out(data_out),
    .valid_out(valid_out),
    .command(command),
    .mem_addr(mem_addr),
    .mem_response(mem_response),
    .mem_data(mem_data),
    .mem_data_tag(mem_data_tag)
  );

  mem_model #(.DATA_KEY(data_key)) mem_model_i (
    .clock(clock),
    .reset(reset),
    .command(command),
    .mem_addr(mem_addr),
    .mem_response(mem_response),
    .mem_data(mem_data),
    .mem_data_tag(mem_data_tag)
  );

  function automatic logic [63:0] expected_line(input logic [28:0] line);
    return {35'b0, line} * data_key;
  endfunction

  function automatic logic resident(input logic [28:0] line);
    int   set;
    logic found;
    set = int'(line % num_sets);
    found = 1'b0;
    for (int w = 0; w < num_ways; w++) begin
      if (model_valid[set][w] && (model_line[set][w] == line)) begin
        found = 1'b1;
      end
    end
    return found;
  endfunction

  function automatic logic was_evicted(input logic [28:0] line);
    foreach (evicted_lines[i]) begin
      if (evicted_lines[i] == line) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  //////////////////////////////////////////////////
  // bus and data checks
  //////////////////////////////////////////////////

  always @(posedge clock) begin
    logic [28:0] ret_line;
    int          set;
    int          way;
    if (reset) begin
      pending_busy <= '0;
      refused_q <= 1'b0;
      for (int s = 0; s < num_sets; s++) begin
        model_valid[s] <= '0;
        model_victim[s] <= 0;
      end
    end else begin
      if (valid_out) begin
        assert (data_out == expected_line(fetch_addr[31:3])) else begin
          data_errors++;
          $display("[FAIL] %0t: fetch %h gave data %h, expected %h", $time, fetch_addr,
                   data_out, expected_line(fetch_addr[31:3]));
        end
      end
      if (refused_q) begin
        assert (command == mem_bus_pkg::bus_load && mem_addr == refused_addr_q) else begin
          request_errors++;
          $display("[FAIL] %0t: refused request %h changed to %h", $time,
                   refused_addr_q, mem_addr);
        end
      end
      refused_q <= (command == mem_bus_pkg::bus_load) && (mem_response == mem_bus_pkg::no_tag);
      refused_addr_q <= mem_addr;
      if (mem_response != mem_bus_pkg::no_tag) begin
        assert (mem_addr[2:0] == 3'b000) else begin
          request_errors++;
          $display("[FAIL] %0t: load address %h is not line-aligned", $time, mem_addr);
        end
        for (int t = 1; t <= num_tags; t++) begin
          assert (!(pending_busy[t] && pending_line[t] == mem_addr[31:3])) else begin
            request_errors++;
            $display("[FAIL] %0t: load %h issued while tag %0d holds it", $time, mem_addr, t);
          end
        end
        pending_busy[mem_response] <= 1'b1;
        pending_line[mem_response] <= mem_addr[31:3];
      end
      // round-robin fill skipped when the line is already present
      if (mem_data_tag != mem_bus_pkg::no_tag) begin
        ret_line = pending_line[mem_data_tag];
        set = int'(ret_line % num_sets);
        way = model_victim[set];
        pending_busy[mem_data_tag] <= 1'b0;
        if (!resident(ret_line)) begin
          if (model_valid[set][way]) begin
            evicted_lines.push_back(model_line[set][way]);
          end
          model_line[set][way] <= ret_line;
          model_valid[set][way] <= 1'b1;
          model_victim[set] <= (way + 1) % num_ways;
        end
      end
    end
  end

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("run stopped after %0d cycles with tests still running", cycles);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  task automatic fetch_until_valid(input logic [31:0] addr);
    int waited;
    waited = 0;
    fetch_addr <= addr;
    do begin
      @(posedge clock);
      waited++;
    end while (!valid_out && waited < wait_limit);
    assert (valid_out) else begin
      miss_errors++;
      $display("fetch address %h was still not valid after %0d cycles", addr, waited);
    end
  endtask

  // no loads pending and the queue quiet for a while
  task automatic wait_idle();
    int quiet;
    quiet = 0;
    while (quiet < 16) begin
      @(posedge clock);
      if (command == mem_bus_pkg::bus_none && pending_busy == '0) begin
        quiet++;
      end else begin
        quiet = 0;
      end
    end
  endtask

  task automatic prefetch_test(input logic [31:0] addr);
    logic [28:0] next_line;
    wait_idle();
    fetch_until_valid(addr);
    wait_idle();
    for (int k = 1; k <= 2; k++) begin
      next_line = addr[31:3] + 29'(k);
      if (!(was_evicted(next_line) && !resident(next_line))) begin
        fetch_addr <= addr + 32'(8 * k);
        @(posedge clock);
        assert (valid_out) else begin
          prefetch_errors++;
          $display("[FAIL] %0t: prefetched line %h not valid on first fetch", $time,
                   next_line);
        end
      end
    end
  endtask

  initial begin
    void'($urandom(86));
    reset = 1'b1;
    fetch_addr = '0;
    repeat (10) @(posedge clock);
    assert (command == mem_bus_pkg::bus_none && !valid_out) else begin
      reset_errors++;
      $display("[FAIL] %0t: after reset command %0d valid_out %b", $time, command, valid_out);
    end
    reset <= 1'b0;
    @(posedge clock);
    for (int i = 0; i < 32; i++) begin
      fetch_until_valid(32'h0000_0100 + 32'(4 * i));
    end
    for (int i = 0; i < 32; i++) begin
      fetch_until_valid(32'h0000_0400 + 32'(4 * i));
    end
    for (int i = 0; i < 40; i++) begin
      fetch_until_valid($urandom_range(0, 4095) & ~32'h3);
    end
    // six lines of one set against four ways
    for (int pass = 0; pass < 4; pass++) begin
      for (int k = 0; k < 6; k++) begin
        fetch_until_valid(32'h0000_2000 + 32'(64 * k));
      end
    end
    prefetch_test(32'h0000_8000);
    prefetch_test(32'h0000_9010);
    @(negedge clock);
    total_errors = reset_errors + data_errors + request_errors + miss_errors + prefetch_errors;
    $display("errors: reset %0d, data %0d, request %0d, miss %0d, prefetch %0d",
             reset_errors, data_errors, request_errors, miss_errors, prefetch_errors);
    if (total_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- bench/mem_model.sv
`timescale 1ns/1ps

module mem_model #(
  parameter logic [63:0] DATA_KEY = 64'h9e37_79b9_7f4a_7c15
) (
  input  logic                      clock,
  input  logic                      reset,
  input  mem_bus_pkg::bus_command_t command,
  input  logic [31:0]               mem_addr,
  output mem_bus_pkg::mem_tag_t     mem_response,
  output logic [63:0]               mem_data,
  output mem_bus_pkg::mem_tag_t     mem_data_tag
);
  localparam int num_tags = mem_bus_pkg::num_tags;

  logic [num_tags:1]     busy;
  logic [28:0]           line_of [1:num_tags];
  int                    due     [1:num_tags];
  int                    cycle;
  logic                  accept_q = 1'b0;
  mem_bus_pkg::mem_tag_t free_tag_q = '0;

  initial begin
    mem_data = '0;
    mem_data_tag = mem_bus_pkg::no_tag;
  end

  // answer in the same cycle as the request
  assign mem_response = (command == mem_bus_pkg::bus_load && accept_q) ?
                        free_tag_q : mem_bus_pkg::no_tag;

  always @(posedge clock) begin
    int   start;
    int   t;
    logic found;
    if (reset) begin
      busy = '0;
      cycle = 0;
      accept_q <= 1'b0;
      free_tag_q <= mem_bus_pkg::no_tag;
      mem_data <= '0;
      mem_data_tag <= mem_bus_pkg::no_tag;
    end else begin
      cycle++;
      // tag shown last cycle is free again
      if (mem_data_tag != mem_bus_pkg::no_tag) begin
        busy[mem_data_tag] = 1'b0;
      end
      if (mem_response != mem_bus_pkg::no_tag) begin
        busy[mem_response] = 1'b1;
        line_of[mem_response] = mem_addr[31:3];
        due[mem_response] = cycle + $urandom_range(2, 12);
      end
      // one ready tag per cycle with the search starting at a random tag
      mem_data_tag <= mem_bus_pkg::no_tag;
      start = $urandom_range(0, num_tags - 1);
      found = 1'b0;
      for (int i = 0; i < num_tags; i++) begin
        t = (start + i) % num_tags + 1;
        if (!found && busy[t] && (due[t] <= cycle)) begin
          found = 1'b1;
          mem_data_tag <= mem_bus_pkg::mem_tag_t'(t);
          mem_data <= {35'b0, line_of[t]} * DATA_KEY;
        end
      end
      // free tag for the next cycle
      // about one request in four is refused
      start = $urandom_range(0, num_tags - 1);
      found = 1'b0;
      for (int i = 0; i < num_tags; i++) begin
        t = (start + i) % num_tags + 1;
        if (!found && !busy[t]) begin
          found = 1'b1;
          free_tag_q <= mem_bus_pkg::mem_tag_t'(t);
        end
      end
      accept_q <= found && ($urandom_range(0, 3) != 0);
    end
  end

endmodule

//--- filelist.f
source/icache_pkg.sv
source/mem_bus_pkg.sv
source/icache_if.sv
source/cache_mem.sv
source/miss_queue.sv
source/fill_tracker.sv
source/icache.sv
bench/mem_model.sv
bench/icache_tb.sv

//--- run.sh
#!/bin/sh
# build and run the icache testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 --top-module icache_tb \
    -f filelist.f -o icache_sim; then
  echo "verilator build failed"
  exit 1
fi

if ! ./obj_dir/icache_sim > sim.log 2>&1; then
  cat sim.log
  echo "simulation exited with an error"
  exit 1
fi

cat sim.log
if grep -q "ALL TESTS PASSED" sim.log; then
  exit 0
else
  echo "pass message not found in sim.log"
  exit 1
fi

//--- source/cache_mem.sv
`timescale 1ns/1ps

module cache_mem #(
  parameter int NUM_WAYS = 4,
  parameter int NUM_SETS = 8
) (
  input  logic    clock,
  input  logic    reset,
  lookup_if.cache lookup0,
  lookup_if.cache lookup1,
  fill_if.cache   fill
);
  localparam int index_bits = $clog2(NUM_SETS);
  localparam int tag_bits = icache_pkg::line_addr_width - index_bits;
  localparam int way_bits = $clog2(NUM_WAYS);

  logic [NUM_WAYS-1:0]               valid_q  [NUM_SETS];
  logic [way_bits-1:0]               victim_q [NUM_SETS];
  logic [tag_bits-1:0]               tag_q    [NUM_SETS][NUM_WAYS];
  logic [icache_pkg::line_width-1:0] data_q   [NUM_SETS][NUM_WAYS];

  logic [NUM_WAYS-1:0] match0;
  logic [NUM_WAYS-1:0] match1;
  logic [NUM_WAYS-1:0] match_fill;
  logic                fill_new;
  logic [way_bits-1:0] fill_way;

  function automatic logic [NUM_WAYS-1:0] match_ways(
    input logic [index_bits-1:0] index,
    input logic [tag_bits-1:0]   tag
  );
    logic [NUM_WAYS-1:0] ways;
    for (int w = 0; w < NUM_WAYS; w++) begin
      ways[w] = valid_q[index][w] && (tag_q[index][w] == tag);
    end
    return ways;
  endfunction

  function automatic logic [icache_pkg::line_width-1:0] select_line(
    input logic [index_bits-1:0] index,
    input logic [NUM_WAYS-1:0]   ways
  );
    logic [icache_pkg::line_width-1:0] line;
    line = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (ways[w]) begin
        line = line | data_q[index][w];
      end
    end
    return line;
  endfunction

  //////////////////////////////////////////////////
  // lookup ports
  //////////////////////////////////////////////////

  always_comb begin
    match0 = lookup0.en ? match_ways(lookup0.index, lookup0.tag) : '0;
    match1 = lookup1.en ? match_ways(lookup1.index, lookup1.tag) : '0;
    lookup0.hit = |match0;
    lookup1.hit = |match1;
    lookup0.data = select_line(lookup0.index, match0);
    lookup1.data = select_line(lookup1.index, match1);
  end

  //////////////////////////////////////////////////
  // fill and round-robin victim
  //////////////////////////////////////////////////

  // a line already present is left alone
  always_comb begin
    match_fill = match_ways(fill.index, fill.tag);
    fill_new = fill.en && (match_fill == '0);
    fill_way = victim_q[fill.index];
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        valid_q[s] <= '0;
        victim_q[s] <= '0;
      end
    end else if (fill_new) begin
      valid_q[fill.index][fill_way] <= 1'b1;
      if (fill_way == way_bits'(NUM_WAYS - 1)) begin
        victim_q[fill.index] <= '0;
      end else begin
        victim_q[fill.index] <= fill_way + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (fill_new) begin
      tag_q[fill.index][fill_way] <= fill.tag;
      data_q[fill.index][fill_way] <= fill.data;
    end
  end

  // duplicate fills must never create a second copy of a line
  one_way_hit0: assert property (@(posedge clock) disable iff (reset) $onehot0(match0));
  one_way_hit1: assert property (@(posedge clock) disable iff (reset) $onehot0(match1));

endmodule

//--- source/fill_tracker.sv
`timescale 1ns/1ps

module fill_tracker #(
  parameter int NUM_SETS = 8
) (
  input  logic                                   clock,
  input  logic                                   reset,
  input  logic                                   issue,
  input  mem_bus_pkg::mem_tag_t                  issued_tag,
  input  logic [icache_pkg::line_addr_width-1:0] issued_line,
  input  logic [icache_pkg::line_width-1:0]      mem_data,
  input  mem_bus_pkg::mem_tag_t                  mem_data_tag,
  fill_if.tracker                                fill
);
  localparam int line_bits = icache_pkg::line_addr_width;
  localparam int index_bits = $clog2(NUM_SETS);
  localparam int num_tags = mem_bus_pkg::num_tags;

  // one slot per nonzero tag
  logic [num_tags:1]    busy_q;
  logic [line_bits-1:0] line_q [1:num_tags];

  logic                              fill_en_q;
  logic [line_bits-1:0]              fill_line_q;
  logic [icache_pkg::line_width-1:0] fill_data_q;
  logic                              returned;

  assign returned = (mem_data_tag != mem_bus_pkg::no_tag);

  always_ff @(posedge clock) begin
    if (reset) begin
      busy_q <= '0;
      fill_en_q <= 1'b0;
    end else begin
      fill_en_q <= returned;
      if (returned) begin
        busy_q[mem_data_tag] <= 1'b0;
      end
      if (issue) begin
        busy_q[issued_tag] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (issue) begin
      line_q[issued_tag] <= issued_line;
    end
    if (returned) begin
      fill_line_q <= line_q[mem_data_tag];
      fill_data_q <= mem_data;
    end
  end

  assign fill.en = fill_en_q;
  assign fill.line = fill_line_q;
  assign fill.index = fill_line_q[index_bits-1:0];
  assign fill.tag = fill_line_q[line_bits-1:index_bits];
  assign fill.data = fill_data_q;

  tag_free_on_issue: assert property (@(posedge clock) disable iff (reset)
    issue |-> !busy_q[issued_tag]);

  // memory answers only for tags it was given
  tag_known_on_return: assert property (@(posedge clock) disable iff (reset)
    returned |-> busy_q[mem_data_tag]);

endmodule

//--- source/icache.sv
`timescale 1ns/1ps

module icache #(
  parameter int NUM_WAYS = 4,
  parameter int NUM_SETS = 8,
  parameter int QUEUE_DEPTH = 8,
  parameter int PREFETCH_COUNT = 2
) (
  input  logic                              clock,
  input  logic                              reset,
  input  logic [icache_pkg::addr_width-1:0] fetch_addr,
  output logic [icache_pkg::line_width-1:0] data_out,
  output logic                              valid_out,
  output mem_bus_pkg::bus_command_t         command,
  output logic [icache_pkg::addr_width-1:0] mem_addr,
  input  mem_bus_pkg::mem_tag_t             mem_response,
  input  logic [icache_pkg::line_width-1:0] mem_data,
  input  mem_bus_pkg::mem_tag_t             mem_data_tag
);
  localparam int index_bits = $clog2(NUM_SETS);
  localparam int index_lsb = icache_pkg::offset_bits;
  localparam int tag_lsb = icache_pkg::offset_bits + index_bits;

  mem_bus_pkg::mem_tag_t                  issued_tag;
  logic [icache_pkg::line_addr_width-1:0] issued_line;
  logic                                   issue;

  lookup_if #(.NUM_SETS(NUM_SETS)) fetch_lookup ();
  lookup_if #(.NUM_SETS(NUM_SETS)) prefetch_lookup ();
  fill_if   #(.NUM_SETS(NUM_SETS)) fill_bus ();

  // fetch port always looks up
  assign fetch_lookup.en = 1'b1;
  assign fetch_lookup.index = fetch_addr[tag_lsb-1:index_lsb];
  assign fetch_lookup.tag = fetch_addr[icache_pkg::addr_width-1:tag_lsb];

  assign data_out = fetch_lookup.data;
  assign valid_out = fetch_lookup.hit;

  cache_mem #(
    .NUM_WAYS(NUM_WAYS),
    .NUM_SETS(NUM_SETS)
  ) cache_mem_i (
    .clock(clock),
    .reset(reset),
    .lookup0(fetch_lookup),
    .lookup1(prefetch_lookup),
    .fill(fill_bus)
  );

  miss_queue #(
    .NUM_SETS(NUM_SETS),
    .QUEUE_DEPTH(QUEUE_DEPTH),
    .PREFETCH_COUNT(PREFETCH_COUNT)
  ) miss_queue_i (
    .clock(clock),
    .reset(reset),
    .fetch_addr(fetch_addr),
    .demand_hit(fetch_lookup.hit),
    .check(prefetch_lookup),
    .fill(fill_bus),
    .command(command),
    .mem_addr(mem_addr),
    .mem_response(mem_response),
    .issued_tag(issued_tag),
    .issued_line(issued_line),
    .issue(issue)
  );

  fill_tracker #(
    .NUM_SETS(NUM_SETS)
  ) fill_tracker_i (
    .clock(clock),
    .reset(reset),
    .issue(issue),
    .issued_tag(issued_tag),
    .issued_line(issued_line),
    .mem_data(mem_data),
    .mem_data_tag(mem_data_tag),
    .fill(fill_bus)
  );

endmodule

//--- source/icache_if.sv
`timescale 1ns/1ps

// combinational lookup with the result in the same cycle
interface lookup_if #(
  parameter int NUM_SETS = 8
);
  localparam int index_bits = $clog2(NUM_SETS);
  localparam int tag_bits = icache_pkg::line_addr_width - index_bits;

  logic                              en;
  logic [index_bits-1:0]             index;
  logic [tag_bits-1:0]               tag;
  logic                              hit;
  logic [icache_pkg::line_width-1:0] data;

  modport requester(output en, index, tag, input hit, data);
  modport cache(input en, index, tag, output hit, data);
endinterface

// one-cycle fill strobe from the tracker
interface fill_if #(
  parameter int NUM_SETS = 8
);
  localparam int index_bits = $clog2(NUM_SETS);
  localparam int tag_bits = icache_pkg::line_addr_width - index_bits;

  logic                                   en;
  logic [index_bits-1:0]                  index;
  logic [tag_bits-1:0]                    tag;
  logic [icache_pkg::line_width-1:0]      data;
  logic [icache_pkg::line_addr_width-1:0] line;

  modport tracker(output en, index, tag, data, line);
  modport cache(input en, index, tag, data);
  modport retire(input en, line);
endinterface

//--- source/icache_pkg.sv
package icache_pkg;

  //////////////////////////////////////////////////
  // cache geometry
  //////////////////////////////////////////////////

  localparam int addr_width = 32;
  localparam int line_width = 64;
  localparam int offset_bits = 3;

  // width of a line-aligned address with the byte offset removed
  localparam int line_addr_width = addr_width - offset_bits;

  //////////////////////////////////////////////////
  // miss queue slot
  //////////////////////////////////////////////////

  // checked means the cache was already searched for this line
  typedef struct packed {
    logic [line_addr_width-1:0] line_addr;
    logic                       valid;
    logic                       checked;
    logic                       issued;
  } queue_entry_t;

endpackage

//--- source/mem_bus_pkg.sv
package mem_bus_pkg;

  // memory command held for as long as a request waits
  typedef enum logic [1:0] {
    bus_none = 2'd0,
    bus_load = 2'd1
  } bus_command_t;

  // transaction tag where zero is reserved
  typedef logic [3:0] mem_tag_t;

  localparam mem_tag_t no_tag = 4'd0;

  // usable tags are one less than the tag space
  localparam int num_tags = (1 << $bits(mem_tag_t)) - 1;

endpackage

//--- source/miss_queue.sv
`timescale 1ns/1ps

module miss_queue #(
  parameter int NUM_SETS = 8,
  parameter int QUEUE_DEPTH = 8,
  parameter int PREFETCH_COUNT = 2
) (
  input  logic                                   clock,
  input  logic                                   reset,
  input  logic [icache_pkg::addr_width-1:0]      fetch_addr,
  input  logic                                   demand_hit,
  lookup_if.requester                            check,
  fill_if.retire                                 fill,
  output mem_bus_pkg::bus_command_t              command,
  output logic [icache_pkg::addr_width-1:0]      mem_addr,
  input  mem_bus_pkg::mem_tag_t                  mem_response,
  output mem_bus_pkg::mem_tag_t                  issued_tag,
  output logic [icache_pkg::line_addr_width-1:0] issued_line,
  output logic                                   issue
);
  localparam int line_bits = icache_pkg::line_addr_width;
  localparam int index_bits = $clog2(NUM_SETS);
  localparam int slot_bits = $clog2(QUEUE_DEPTH);
  // demand line first, then the prefetch lines
  localparam int cand_count = PREFETCH_COUNT + 1;

  icache_pkg::queue_entry_t queue_q [QUEUE_DEPTH];
  icache_pkg::queue_entry_t queue_n [QUEUE_DEPTH];
  icache_pkg::queue_entry_t marked  [QUEUE_DEPTH];
  logic [QUEUE_DEPTH-1:0]   keep;

  logic [line_bits-1:0] last_line_q;
  logic                 last_valid_q;

  logic [line_bits-1:0]  fetch_line;
  logic                  fetch_changed;
  logic [line_bits-1:0]  cand_line [cand_count];
  logic [cand_count-1:0] cand_queued;
  logic [cand_count-1:0] cand_want;

  logic                 check_found;
  logic [slot_bits-1:0] check_slot;
  logic                 pend_found;
  logic [slot_bits-1:0] pend_slot;
  logic                 offer;

  assign fetch_line = fetch_addr[icache_pkg::addr_width-1:icache_pkg::offset_bits];
  assign fetch_changed = !last_valid_q || (fetch_line != last_line_q);

  //////////////////////////////////////////////////
  // content search
  //////////////////////////////////////////////////

  always_comb begin
    for (int k = 0; k < cand_count; k++) begin
      cand_line[k] = fetch_line + line_bits'(k);
      cand_queued[k] = 1'b0;
      for (int i = 0; i < QUEUE_DEPTH; i++) begin
        if (queue_q[i].valid && (queue_q[i].line_addr == cand_line[k])) begin
          cand_queued[k] = 1'b1;
        end
      end
    end
    // demand retried every cycle while it misses
    cand_want[0] = !demand_hit && !cand_queued[0];
    for (int k = 1; k < cand_count; k++) begin
      cand_want[k] = fetch_changed && !demand_hit && !cand_queued[k];
    end
  end

  // lowest slot is oldest
  always_comb begin
    check_found = 1'b0;
    check_slot = '0;
    pend_found = 1'b0;
    pend_slot = '0;
    for (int i = QUEUE_DEPTH - 1; i >= 0; i--) begin
      if (queue_q[i].valid && !queue_q[i].checked) begin
        check_found = 1'b1;
        check_slot = slot_bits'(i);
      end
      if (queue_q[i].valid && !queue_q[i].issued) begin
        pend_found = 1'b1;
        pend_slot = slot_bits'(i);
      end
    end
    // head of line waits for its cache check
    offer = pend_found && queue_q[pend_slot].checked;
  end

  assign check.en = check_found;
  assign check.index = queue_q[check_slot].line_addr[index_bits-1:0];
  assign check.tag = queue_q[check_slot].line_addr[line_bits-1:index_bits];

  //////////////////////////////////////////////////
  // memory request
  //////////////////////////////////////////////////

  assign command = offer ? mem_bus_pkg::bus_load : mem_bus_pkg::bus_none;
  assign mem_addr = offer ?
                    {queue_q[pend_slot].line_addr, {icache_pkg::offset_bits{1'b0}}} : '0;
  assign issue = offer && (mem_response != mem_bus_pkg::no_tag);
  assign issued_tag = mem_response;
  assign issued_line = queue_q[pend_slot].line_addr;

  //////////////////////////////////////////////////
  // next queue state
  //////////////////////////////////////////////////

  always_comb begin
    int tail;
    marked = queue_q;
    for (int i = 0; i < QUEUE_DEPTH; i++) begin
      keep[i] = queue_q[i].valid;
      if (fill.en && queue_q[i].issued && (queue_q[i].line_addr == fill.line)) begin
        keep[i] = 1'b0;
      end
    end
    if (issue) begin
      marked[pend_slot].issued = 1'b1;
    end
    // prefetch of a line already cached is dropped
    if (check_found) begin
      if (check.hit) begin
        keep[check_slot] = 1'b0;
      end else begin
        marked[check_slot].checked = 1'b1;
      end
    end
    for (int i = 0; i < QUEUE_DEPTH; i++) begin
      queue_n[i] = '0;
    end
    // compact, then append at the tail
    tail = 0;
    for (int i = 0; i < QUEUE_DEPTH; i++) begin
      if (keep[i]) begin
        queue_n[tail] = marked[i];
        tail++;
      end
    end
    for (int k = 0; k < cand_count; k++) begin
      if (cand_want[k] && (tail < QUEUE_DEPTH)) begin
        queue_n[tail] = '{line_addr: cand_line[k], valid: 1'b1,
                          checked: (k == 0), issued: 1'b0};
        tail++;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < QUEUE_DEPTH; i++) begin
        queue_q[i] <= '0;
      end
      last_line_q <= '0;
      last_valid_q <= 1'b0;
    end else begin
      queue_q <= queue_n;
      last_line_q <= fetch_line;
      last_valid_q <= 1'b1;
    end
  end

  // refused request is repeated unchanged
  hold_until_accepted: assert property (@(posedge clock) disable iff (reset)
    (command == mem_bus_pkg::bus_load && mem_response == mem_bus_pkg::no_tag)
    |=> (command == mem_bus_pkg::bus_load && $stable(mem_addr)));

endmodule
